// File: project.f
rtl/rv_pkg.sv
rtl/decode.sv
rtl/controller.sv
rtl/regfile.sv
rtl/alu.sv
rtl/lsu.sv
rtl/core.sv
sim/core_assertions.sv
sim/tb_core.sv

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu (
  input  logic [31:0]     a, b,              // selected operands
  input  rv_pkg::alu_op_e op,
  input  logic [31:0]     rs1_val, rs2_val,  // raw register values for compare
  input  logic [2:0]      funct3,            // branch condition
  output logic [31:0]     res,
  output logic            taken
);

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    res = a + b;
      rv_pkg::ALU_SUB:    res = a - b;
      rv_pkg::ALU_SLL:    res = a << b[4:0];  // shamt is low 5 bits
      rv_pkg::ALU_SLT:    res = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU:   res = {31'd0, a < b};
      rv_pkg::ALU_XOR:    res = a ^ b;
      rv_pkg::ALU_SRL:    res = a >> b[4:0];
      rv_pkg::ALU_SRA:    res = $unsigned($signed(a) >>> b[4:0]);
      rv_pkg::ALU_OR:     res = a | b;
      rv_pkg::ALU_AND:    res = a & b;
      rv_pkg::ALU_PASS_B: res = b;
      default:            res = 32'd0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = (rs1_val == rs2_val);                    // beq
      3'b001:  taken = (rs1_val != rs2_val);                    // bne
      3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));   // blt
      3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));  // bge
      3'b110:  taken = (rs1_val < rs2_val);                     // bltu
      3'b111:  taken = (rs1_val >= rs2_val);                    // bgeu
      default: taken = 1'b0;                                    // reserved codes
    endcase
  end

endmodule

// File: rtl/controller.sv
`timescale 1ns/1ns

module controller (
  input  rv_pkg::decoded_s dec,
  output rv_pkg::ctrl_s    ctrl
);

  rv_pkg::alu_op_e funct_op;  // alu op picked by funct3/funct7

  always_comb begin
    case (dec.funct3)
      3'b000:  funct_op = (dec.op == rv_pkg::OPC_OP && dec.funct7[5]) ? rv_pkg::ALU_SUB
                                                                     : rv_pkg::ALU_ADD;
      3'b001:  funct_op = rv_pkg::ALU_SLL;
      3'b010:  funct_op = rv_pkg::ALU_SLT;
      3'b011:  funct_op = rv_pkg::ALU_SLTU;
      3'b100:  funct_op = rv_pkg::ALU_XOR;
      3'b101:  funct_op = dec.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;  // srai too
      3'b110:  funct_op = rv_pkg::ALU_OR;
      default: funct_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl            = '0;  // unknown opcode acts as nop
    ctrl.store_size = rv_pkg::SZ_READ;
    ctrl.alu_op     = rv_pkg::ALU_ADD;
    ctrl.wd_sel     = rv_pkg::WD_ALU;
    case (dec.op)
      rv_pkg::OPC_LUI: begin
        ctrl.we_reg    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = rv_pkg::ALU_PASS_B;  // address output just mirrors imm
        ctrl.wd_sel    = rv_pkg::WD_IMM;
      end
      rv_pkg::OPC_AUIPC: begin
        ctrl.we_reg    = 1'b1;
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        ctrl.we_reg    = 1'b1;
        ctrl.jal       = 1'b1;
        ctrl.a_sel_pc  = 1'b1;  // target = pc + imm
        ctrl.b_sel_imm = 1'b1;
        ctrl.wd_sel    = rv_pkg::WD_PC4;
      end
      rv_pkg::OPC_JALR: begin
        ctrl.we_reg    = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.b_sel_imm = 1'b1;  // target = rs1 + imm
        ctrl.wd_sel    = rv_pkg::WD_PC4;
      end
      rv_pkg::OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.a_sel_pc  = 1'b1;  // alu builds the target, compare is separate
        ctrl.b_sel_imm = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        ctrl.we_reg    = 1'b1;
        ctrl.mem_en    = 1'b1;
        ctrl.is_load   = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.wd_sel    = rv_pkg::WD_MEM;
      end
      rv_pkg::OPC_STORE: begin
        ctrl.mem_en     = 1'b1;
        ctrl.b_sel_imm  = 1'b1;
        ctrl.store_size = rv_pkg::store_size_e'(dec.funct3[1:0]);  // 00 b, 01 h, 10 w
      end
      rv_pkg::OPC_OP_IMM: begin
        ctrl.we_reg    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = funct_op;
      end
      rv_pkg::OPC_OP: begin
        ctrl.we_reg = 1'b1;
        ctrl.alu_op = funct_op;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/core.sv
`timescale 1ns/1ns

module core #(
  parameter logic [31:0] RESET_PC = 32'd0
) (
  input  logic                CLK,
  input  logic                rst,
  input  logic                stall_mem,       // memory busy, freeze core
  input  logic [31:0]         instr_fetch,     // word at pc
  input  logic [31:0]         mem_read_data,
  output logic                memory_en,       // access strobe
  output rv_pkg::store_size_e store_size,      // width or READ
  output logic [31:0]         nextPC,          // fetch address for next cycle
  output logic [31:0]         mem_write_data,
  output logic [31:0]         mem_addr
);

  rv_pkg::decoded_s dec;
  rv_pkg::ctrl_s    ctrl;
  logic [31:0] pc, pc_plus4;
  logic [31:0] rd1, rd2, op_a, op_b, alu_res, load_data, wd;
  logic        taken, we;

  decode u_decode (.instr(instr_fetch), .dec(dec));

  controller u_controller (.dec(dec), .ctrl(ctrl));

  regfile u_regfile (
    .CLK(CLK), .we(we), .rd(dec.rd), .rs1(dec.rs1), .rs2(dec.rs2),
    .wd(wd), .rd1(rd1), .rd2(rd2)
  );

  assign op_a = ctrl.a_sel_pc ? pc : rd1;        // pc for auipc/jal/branch
  assign op_b = ctrl.b_sel_imm ? dec.imm : rd2;

  alu u_alu (
    .a(op_a), .b(op_b), .op(ctrl.alu_op), .rs1_val(rd1), .rs2_val(rd2),
    .funct3(dec.funct3), .res(alu_res), .taken(taken)
  );

  lsu u_lsu (
    .is_load(ctrl.is_load), .funct3(dec.funct3), .mem_read_data(mem_read_data),
    .rs2_val(rd2), .load_data(load_data), .mem_write_data(mem_write_data)
  );

  assign mem_addr   = alu_res;                   // base + offset
  assign memory_en  = ctrl.mem_en & ~rst;        // no access while in reset
  assign store_size = ctrl.store_size;
  assign we         = ctrl.we_reg & ~stall_mem & ~rst;  // write only on retiring edge
  assign pc_plus4   = pc + 32'd4;

  always_comb begin
    case (ctrl.wd_sel)
      rv_pkg::WD_ALU: wd = alu_res;
      rv_pkg::WD_MEM: wd = load_data;
      rv_pkg::WD_PC4: wd = pc_plus4;             // link value
      default:        wd = dec.imm;              // lui
    endcase
  end

  always_comb begin
    if (stall_mem) begin
      nextPC = pc;                               // hold fetch while memory busy
    end else if (ctrl.jalr) begin
      nextPC = {alu_res[31:1], 1'b0};            // lsb cleared per spec
    end else if (ctrl.jal || (ctrl.branch && taken)) begin
      nextPC = alu_res;
    end else begin
      nextPC = pc_plus4;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!stall_mem) begin
      pc <= nextPC;                              // retire one instruction
    end
  end

endmodule

// File: rtl/decode.sv
`timescale 1ns/1ns

module decode (
  input  logic [31:0]      instr,  // fetched instruction word
  output rv_pkg::decoded_s dec     // sliced fields + immediate
);

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};  // low bits zero
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.op     = rv_pkg::opcode_e'(instr[6:0]);  // unknown codes pass through
    dec.rd     = instr[11:7];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.funct3 = instr[14:12];
    dec.funct7 = instr[31:25];
    case (dec.op)
      rv_pkg::OPC_LUI,
      rv_pkg::OPC_AUIPC:  dec.imm = imm_u;
      rv_pkg::OPC_JAL:    dec.imm = imm_j;
      rv_pkg::OPC_BRANCH: dec.imm = imm_b;
      rv_pkg::OPC_STORE:  dec.imm = imm_s;
      default:            dec.imm = imm_i;  // jalr, loads, op-imm
    endcase
  end

endmodule

// File: rtl/lsu.sv
`timescale 1ns/1ns

module lsu (
  input  logic        is_load,
  input  logic [2:0]  funct3,          // access width and signedness
  input  logic [31:0] mem_read_data,
  input  logic [31:0] rs2_val,         // store source
  output logic [31:0] load_data,
  output logic [31:0] mem_write_data
);

  // load formatting, zero when not a load
  always_comb begin
    if (is_load) begin
      case (funct3)
        3'b000:  load_data = {{24{mem_read_data[7]}}, mem_read_data[7:0]};    // lb
        3'b001:  load_data = {{16{mem_read_data[15]}}, mem_read_data[15:0]};  // lh
        3'b010:  load_data = mem_read_data;                                   // lw
        3'b100:  load_data = {24'd0, mem_read_data[7:0]};                     // lbu
        3'b101:  load_data = {16'd0, mem_read_data[15:0]};                    // lhu
        default: load_data = 32'd0;
      endcase
    end else begin
      load_data = 32'd0;
    end
  end

  // store data, upper bytes cleared per width
  always_comb begin
    case (funct3)
      3'b000:  mem_write_data = {24'd0, rs2_val[7:0]};   // sb
      3'b001:  mem_write_data = {16'd0, rs2_val[15:0]};  // sh
      3'b010:  mem_write_data = rs2_val;                 // sw
      default: mem_write_data = 32'd0;
    endcase
  end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ns

module regfile (
  input  logic        CLK,
  input  logic        we,             // already gated by stall and reset
  input  logic [4:0]  rd, rs1, rs2,
  input  logic [31:0] wd,
  output logic [31:0] rd1, rd2        // combinational read ports
);

  logic [31:0] regs [32];  // entry 0 never written

  always_ff @(posedge CLK) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];  // x0 hard zero
  assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,  // load upper immediate
    OPC_AUIPC  = 7'b0010111,  // add upper immediate to pc
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,  // beq/bne/blt/bge/bltu/bgeu
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,  // register-immediate alu ops
    OPC_OP     = 7'b0110011   // register-register alu ops
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WD_ALU = 2'b00,  // alu result
    WD_MEM = 2'b01,  // formatted load data
    WD_PC4 = 2'b10,  // link address
    WD_IMM = 2'b11   // upper immediate
  } wd_sel_e;

  // same encoding the memory side expects on store_size
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10,
    SZ_READ = 2'b11
  } store_size_e;

  typedef struct packed {
    opcode_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;     // already sign extended
  } decoded_s;

  typedef struct packed {
    logic        we_reg;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic        mem_en;
    store_size_e store_size;
    alu_op_e     alu_op;
    logic        a_sel_pc;   // pc as operand a
    logic        b_sel_imm;  // immediate as operand b
    wd_sel_e     wd_sel;
    logic        is_load;
  } ctrl_s;

endpackage

// File: run.sh
#!/usr/bin/env bash
# build tb_core with Verilator, run it, and judge the result from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
  -f project.f --Mdir obj_dir -o tb_core
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build failed"
  exit 1
fi

./obj_dir/tb_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "FAIL: simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL: pass message not found in $LOG"
exit 1

// File: sim/core_assertions.sv
`timescale 1ns/1ns

module core_assertions (
  input logic        CLK,
  input logic        rst,
  input logic        stall_mem,
  input logic        memory_en,
  input logic [31:0] pc
);

  pc_aligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // a stalled cycle must not move the pc
  pc_held: assert property (@(posedge CLK) disable iff (rst) stall_mem |=> $stable(pc))
    else $error("pc changed after a stalled cycle");

  no_access_in_reset: assert property (@(posedge CLK) rst |-> !memory_en)
    else $error("memory_en high while in reset");

endmodule

bind core core_assertions u_core_assertions (
  .CLK(CLK), .rst(rst), .stall_mem(stall_mem), .memory_en(memory_en), .pc(pc)
);

// File: sim/tb_core.sv
`timescale 1ns/1ns

module tb_core;

  localparam int BODY_END = 150;  // first slot of the register dump block

  logic                CLK;
  logic                rst = 1'b1;
  logic                stall_mem = 1'b0;
  logic [31:0]         instr_fetch, mem_read_data, nextPC, mem_write_data, mem_addr;
  logic                memory_en;
  rv_pkg::store_size_e store_size;

  logic [31:0] imem [256];
  logic [7:0]  dmem [4096];          // byte wide, indexed by mem_addr[11:0]
  logic [31:0] fetch_pc = 32'd0;     // pc the fetch port answers for
  logic [1:0]  stall_cnt = 2'd0;     // stall cycles still to go
  int          prog_len;
  logic [31:0] end_addr;             // final spin jump

  // reference model state
  logic [31:0]         sh_pc;
  logic [31:0]         sh_regs [32];
  logic [7:0]          sh_mem [4096];
  logic                exp_en;
  rv_pkg::store_size_e exp_size;
  logic [31:0]         exp_addr, exp_wdata, exp_next;

  core DUT (
    .CLK(CLK), .rst(rst), .stall_mem(stall_mem), .instr_fetch(instr_fetch),
    .mem_read_data(mem_read_data), .memory_en(memory_en), .store_size(store_size),
    .nextPC(nextPC), .mem_write_data(mem_write_data), .mem_addr(mem_addr)
  );

  assign instr_fetch   = imem[fetch_pc[9:2]];
  assign mem_read_data = {dmem[mem_addr[11:0] + 12'd3], dmem[mem_addr[11:0] + 12'd2],
                          dmem[mem_addr[11:0] + 12'd1], dmem[mem_addr[11:0]]};  // little endian

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
      input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs1, rs2,
      input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr * 37) ^ 8'(addr >> 4);  // mixes all 12 address bits
  endfunction

  function automatic logic is_mem_op(input logic [31:0] w);
    return w[6:0] == 7'b0000011 || w[6:0] == 7'b0100011;
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // random program: reset-pc load, register init, random body, dump of every register, spin
  task automatic build_program();
    int          kind;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    prog_len = 0;
    for (int i = 0; i < 256; i++) imem[i] = 32'd0;
    emit(i_type(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));  // lw x1, 0(x0) sits at the reset pc
    emit({20'd1, 5'd31, 7'b0110111});  // lui x31, 1 gives data base 0x1000
    for (int r = 1; r < 31; r++) emit(i_type(12'($urandom), 5'd0, 3'b000, 5'(r), 7'b0010011));
    while (prog_len < BODY_END) begin
      kind = $urandom_range(0, 9);
      rd   = 5'($urandom_range(1, 30));  // x31 keeps the base
      rs1  = 5'($urandom_range(0, 31));
      rs2  = 5'($urandom_range(0, 31));
      f3   = 3'($urandom);
      imm  = 12'($urandom);
      f7   = ((f3 == 3'b000 || f3 == 3'b101) && imm[11]) ? 7'h20 : 7'h00;  // sub, sra
      case (kind)
        0, 1: emit({f7, rs2, rs1, f3, rd, 7'b0110011});
        2, 3: begin
          if (f3 == 3'b001 || f3 == 3'b101) imm = {f7, imm[4:0]};  // shift amount form
          emit(i_type(imm, rs1, f3, rd, 7'b0010011));
        end
        4: emit({20'($urandom), rd, imm[0] ? 7'b0110111 : 7'b0010111});
        5: begin
          f3 = 3'($urandom_range(0, 5));
          if (f3 == 3'b011) f3 = 3'b010;
          imm = {6'd0, imm[5:0]} & ~((12'd1 << f3[1:0]) - 12'd1);  // aligned in window
          if (rs2[0] && prog_len + 2 <= BODY_END) begin  // pointer chase, base is also rd
            emit({20'd1, rd, 7'b0110111});
            emit(i_type(imm, rd, f3, rd, 7'b0000011));
          end else begin
            emit(i_type(imm, 5'd31, f3, rd, 7'b0000011));
          end
        end
        6: begin
          f3  = 3'($urandom_range(0, 2));
          imm = {6'd0, imm[5:0]} & ~((12'd1 << f3[1:0]) - 12'd1);
          emit(s_type(imm, rs2, 5'd31, f3));
        end
        default: begin
          if (prog_len + 3 <= BODY_END) begin  // forward targets stay in the program
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no reserved branch codes
            if (kind == 7) emit(b_type(13'(8 + 4 * imm[0]), rs1, rs2, f3));
            else if (kind == 8) emit(j_type(21'(8 + 4 * imm[0]), rd));
            else emit(i_type(12'(4 * (prog_len + 2) + 1), 5'd0, 3'b000, rd, 7'b1100111));
          end
        end
      endcase
    end
    for (int r = 0; r < 32; r++) emit(s_type(12'(256 + 4 * r), 5'(r), 5'd31, 3'b010));
    end_addr = 32'(prog_len * 4);
    emit(j_type(21'd0, 5'd0));  // jal x0, 0
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x, y,
      input logic alt);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x, y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // one instruction at sh_pc: sets the exp_* outputs, updates state when commit
  function automatic void ref_step(input logic commit);
    logic [31:0] ins, a, b, res, npc, word, imm_i;
    logic [11:0] ea;
    logic        wr;
    int          nb;
    ins       = imem[sh_pc[9:2]];
    a         = sh_regs[ins[19:15]];
    b         = sh_regs[ins[24:20]];
    imm_i     = {{20{ins[31]}}, ins[31:20]};
    npc       = sh_pc + 32'd4;
    res       = 32'd0;
    wr        = 1'b1;
    exp_en    = 1'b0;
    exp_size  = rv_pkg::SZ_READ;
    exp_addr  = 32'd0;
    exp_wdata = 32'd0;
    case (ins[6:0])
      7'b0110111: res = {ins[31:12], 12'd0};           // lui
      7'b0010111: res = sh_pc + {ins[31:12], 12'd0};   // auipc
      7'b1101111: begin
        res = npc;
        npc = sh_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        res = npc;
        npc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        wr = 1'b0;
        if (branch_taken(ins[14:12], a, b))
          npc = sh_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b0000011: begin
        exp_en   = 1'b1;
        exp_addr = a + imm_i;
        ea       = exp_addr[11:0];
        word     = {sh_mem[ea + 12'd3], sh_mem[ea + 12'd2], sh_mem[ea + 12'd1], sh_mem[ea]};
        case (ins[14:12])
          3'b000:  res = 32'($signed(word[7:0]));
          3'b001:  res = 32'($signed(word[15:0]));
          3'b100:  res = {24'd0, word[7:0]};
          3'b101:  res = {16'd0, word[15:0]};
          default: res = word;
        endcase
      end
      7'b0100011: begin
        wr        = 1'b0;
        exp_en    = 1'b1;
        exp_addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ea        = exp_addr[11:0];
        nb        = (ins[13:12] == 2'b00) ? 1 : (ins[13:12] == 2'b01) ? 2 : 4;
        exp_size  = (nb == 1) ? rv_pkg::SZ_BYTE : (nb == 2) ? rv_pkg::SZ_HALF : rv_pkg::SZ_WORD;
        exp_wdata = (nb == 4) ? b : b & ((32'd1 << (8 * nb)) - 32'd1);
        if (commit) begin
          for (int i = 0; i < nb; i++) sh_mem[ea + 12'(i)] = exp_wdata[8 * i +: 8];
        end
      end
      7'b0010011: res = alu_ref(ins[14:12], a, imm_i, ins[30] && ins[14:12] == 3'b101);
      7'b0110011: res = alu_ref(ins[14:12], a, b, ins[30]);
      default:    wr = 1'b0;
    endcase
    exp_next = npc;
    if (commit) begin
      if (wr && ins[11:7] != 5'd0) sh_regs[ins[11:7]] = res;
      sh_pc = npc;
    end
  endfunction

  task automatic stop_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic compare_word(input logic [31:0] actual, expected, input string what);
    if (actual !== expected) stop_run($sformatf("%s is %h, expected %h", what, actual, expected));
  endtask

  task automatic compare_access(input logic en, input rv_pkg::store_size_e size,
      input logic [31:0] addr, wdata, input logic e_en, input rv_pkg::store_size_e e_size,
      input logic [31:0] e_addr, e_wdata);
    if (en !== e_en) stop_run($sformatf("memory_en is %b, expected %b", en, e_en));
    if (e_en) begin
      if (size !== e_size) stop_run($sformatf("store_size is %0d, expected %0d", size, e_size));
      compare_word(addr, e_addr, "mem_addr");
      if (e_size != rv_pkg::SZ_READ) compare_word(wdata, e_wdata, "mem_write_data");
    end
  endtask

  // fetch address and stall pattern for the cycle after this edge
  always @(posedge CLK) begin : drive_inputs
    logic [1:0] n;
    n = 2'($urandom_range(0, 3));
    fetch_pc <= rst ? 32'd0 : nextPC;  // 0 is the default RESET_PC
    if (rst) begin
      stall_mem <= 1'b0;
      stall_cnt <= 2'd0;
    end else if (stall_cnt != 2'd0) begin
      stall_cnt <= stall_cnt - 2'd1;
      stall_mem <= (stall_cnt > 2'd1);
    end else if (is_mem_op(imem[nextPC[9:2]])) begin
      stall_cnt <= n;
      stall_mem <= (n != 2'd0);
    end else begin
      stall_mem <= 1'b0;
    end
  end

  always @(posedge CLK) begin  // data memory commits on a retiring edge
    if (!rst && !stall_mem && memory_en && store_size != rv_pkg::SZ_READ) begin
      dmem[mem_addr[11:0]] <= mem_write_data[7:0];
      if (store_size != rv_pkg::SZ_BYTE) dmem[mem_addr[11:0] + 12'd1] <= mem_write_data[15:8];
      if (store_size == rv_pkg::SZ_WORD) begin
        dmem[mem_addr[11:0] + 12'd2] <= mem_write_data[23:16];
        dmem[mem_addr[11:0] + 12'd3] <= mem_write_data[31:24];
      end
    end
  end

  // outputs are settled at the falling edge
  always @(negedge CLK) begin
    if (rst) begin
      if (memory_en !== 1'b0) stop_run("memory_en is high during reset");
    end else begin
      ref_step(!stall_mem);  // only advances the shadow pc when not stalled
      compare_word(nextPC, stall_mem ? sh_pc : exp_next, "nextPC");
      compare_access(memory_en, store_size, mem_addr, mem_write_data,
                     exp_en, exp_size, exp_addr, exp_wdata);
    end
  end

  initial begin : main
    int cycles;
    void'($urandom(32'hdf9e));
    build_program();
    for (int i = 0; i < 4096; i++) begin
      dmem[i]   <= fill_byte(i);
      sh_mem[i] = fill_byte(i);
    end
    for (int r = 0; r < 32; r++) sh_regs[r] = 32'd0;
    sh_pc = 32'd0;
    repeat (2) @(posedge CLK);
    rst <= 1'b0;
    cycles = 0;
    while (sh_pc != end_addr && cycles < 4000) begin
      @(posedge CLK);
      cycles++;
    end
    @(posedge CLK);  // spin jump gets compared on the falling edge before this
    if (sh_pc != end_addr) begin
      $display("timeout: the program did not reach its final jump in 4000 cycles");
      $display("Test failures found");
      $fatal(1, "simulation timed out");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule
